//--- design/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    localparam logic [INST_W-1:0] INST_ECALL  = 32'h0000_0073;
    localparam logic [INST_W-1:0] INST_EBREAK = 32'h0010_0073;
    localparam logic [INST_W-1:0] INST_MRET   = 32'h3020_0073;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;   // imm[11:5]
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;   // imm[4:0]
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;      // imm[31:12]
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_inst_t;

    typedef enum logic [3:0] {
        CLS_OP, CLS_OP_IMM, CLS_OP_32, CLS_OP_IMM_32, CLS_LOAD, CLS_STORE, CLS_LUI,
        CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_BRANCH, CLS_SYSTEM, CLS_ILLEGAL
    } inst_class_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
    } imm_fmt_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {SRC_A_REG, SRC_A_PC, SRC_A_ZERO} src_a_e;
    typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_FOUR} src_b_e;

    typedef enum logic [2:0] {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU} br_cond_e;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD, MEM_DWORD} mem_size_e;

    typedef struct packed {
        logic        valid;
        rv_inst_t    inst;
        inst_class_e cls;
        imm_fmt_e    fmt;
    } field_word_t;

    typedef struct packed {
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        alu_op_e               alu_op;
        src_a_e                src_a;
        src_b_e                src_b;
        logic                  word_op;
        logic                  load;
        logic                  store;
        mem_size_e             mem_size;
        logic                  mem_unsigned;
        logic                  branch;
        br_cond_e              br_cond;
        logic                  jump;
        logic                  jalr;
        logic                  ecall;
        logic                  ebreak;
        logic                  mret;
        logic                  illegal;
    } ctrl_word_t;

endpackage

//--- design/rv_field_stage.sv
`timescale 1ns/10ps

module rv_field_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    input  rv_decode_pkg::rv_inst_t    inst,
    output rv_decode_pkg::field_word_t field
);

    rv_decode_pkg::inst_class_e cls;
    rv_decode_pkg::imm_fmt_e    fmt;
    logic                       shift_f3;

    assign shift_f3 = (inst.r.funct3 == 3'b001) || (inst.r.funct3 == 3'b101); // sll / srl / sra

    always_comb begin
        fmt = rv_decode_pkg::IMM_NONE;
        case (inst.r.opcode)
            rv_decode_pkg::OPC_OP: cls = rv_decode_pkg::CLS_OP;
            rv_decode_pkg::OPC_OP_32: cls = rv_decode_pkg::CLS_OP_32;
            rv_decode_pkg::OPC_OP_IMM: begin
                cls = rv_decode_pkg::CLS_OP_IMM;
                fmt = shift_f3 ? rv_decode_pkg::IMM_SHAMT : rv_decode_pkg::IMM_I;
            end
            rv_decode_pkg::OPC_OP_IMM_32: begin
                cls = rv_decode_pkg::CLS_OP_IMM_32;
                fmt = shift_f3 ? rv_decode_pkg::IMM_SHAMT : rv_decode_pkg::IMM_I;
            end
            rv_decode_pkg::OPC_LOAD: begin
                cls = rv_decode_pkg::CLS_LOAD;
                fmt = rv_decode_pkg::IMM_I;
            end
            rv_decode_pkg::OPC_STORE: begin
                cls = rv_decode_pkg::CLS_STORE;
                fmt = rv_decode_pkg::IMM_S;
            end
            rv_decode_pkg::OPC_LUI: begin
                cls = rv_decode_pkg::CLS_LUI;
                fmt = rv_decode_pkg::IMM_U;
            end
            rv_decode_pkg::OPC_AUIPC: begin
                cls = rv_decode_pkg::CLS_AUIPC;
                fmt = rv_decode_pkg::IMM_U;
            end
            rv_decode_pkg::OPC_JAL: begin
                cls = rv_decode_pkg::CLS_JAL;
                fmt = rv_decode_pkg::IMM_J;
            end
            rv_decode_pkg::OPC_JALR: begin
                cls = rv_decode_pkg::CLS_JALR;
                fmt = rv_decode_pkg::IMM_I;
            end
            rv_decode_pkg::OPC_BRANCH: begin
                cls = rv_decode_pkg::CLS_BRANCH;
                fmt = rv_decode_pkg::IMM_B;
            end
            rv_decode_pkg::OPC_SYSTEM: cls = rv_decode_pkg::CLS_SYSTEM;
            default: cls = rv_decode_pkg::CLS_ILLEGAL;    // unknown opcode
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            field <= '0;
        end else begin
            field.valid <= in_valid;
            field.inst  <= inst;
            field.cls   <= cls;
            field.fmt   <= fmt;
        end
    end

endmodule

//--- design/rv_ctrl_stage.sv
`timescale 1ns/10ps

module rv_ctrl_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  rv_decode_pkg::field_word_t field,
    output logic                       out_valid,
    output rv_decode_pkg::ctrl_word_t  ctrl
);

    rv_decode_pkg::ctrl_word_t nxt;
    logic [2:0]                f3;
    logic [6:0]                f7;
    logic                      f7_ok;      // funct7 is 0000000 or 0100000
    logic                      shift_ok;   // funct6 form for 64-bit shift immediates

    assign f3       = field.inst.r.funct3;
    assign f7       = field.inst.r.funct7;
    assign f7_ok    = (f7 == 7'b0000000) || (f7 == 7'b0100000);
    assign shift_ok = (f7[6:1] == 6'b000000) || (f7[6:1] == 6'b010000 && f3 == 3'b101);

    function automatic rv_decode_pkg::alu_op_e alu_from_f3(input logic [2:0] fn,
                                                         input logic alt);
        case (fn)
            3'b000:  alu_from_f3 = alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
            3'b001:  alu_from_f3 = rv_decode_pkg::ALU_SLL;
            3'b010:  alu_from_f3 = rv_decode_pkg::ALU_SLT;
            3'b011:  alu_from_f3 = rv_decode_pkg::ALU_SLTU;
            3'b100:  alu_from_f3 = rv_decode_pkg::ALU_XOR;
            3'b101:  alu_from_f3 = alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
            3'b110:  alu_from_f3 = rv_decode_pkg::ALU_OR;
            default: alu_from_f3 = rv_decode_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        nxt = '0;
        case (field.cls)
            rv_decode_pkg::CLS_OP, rv_decode_pkg::CLS_OP_32: begin
                nxt.reg_wen = 1'b1;
                nxt.rd      = field.inst.r.rd;
                nxt.rs1     = field.inst.r.rs1;
                nxt.rs2     = field.inst.r.rs2;
                nxt.alu_op  = alu_from_f3(f3, f7[5]);
                nxt.word_op = (field.cls == rv_decode_pkg::CLS_OP_32);
                if (nxt.word_op) begin
                    nxt.illegal = !(f3 == 3'b000 || f3 == 3'b101) ? (f3 != 3'b001 || f7 != 7'b0)
                                                                  : !f7_ok;
                end else begin
                    nxt.illegal = (f7 != 7'b0)
                                  && !(f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
                end
            end
            rv_decode_pkg::CLS_OP_IMM, rv_decode_pkg::CLS_OP_IMM_32: begin
                nxt.reg_wen = 1'b1;
                nxt.rd      = field.inst.i.rd;
                nxt.rs1     = field.inst.i.rs1;
                nxt.src_b   = rv_decode_pkg::SRC_B_IMM;
                nxt.alu_op  = alu_from_f3(f3, f3 == 3'b101 && f7[5]);    // no subi
                nxt.word_op = (field.cls == rv_decode_pkg::CLS_OP_IMM_32);
                if (nxt.word_op) begin
                    nxt.illegal = (f3 == 3'b101) ? !f7_ok
                                                 : !(f3 == 3'b000 || (f3 == 3'b001 && f7 == 7'b0));
                end else begin
                    nxt.illegal = (f3 == 3'b001 || f3 == 3'b101) && !shift_ok;
                end
            end
            rv_decode_pkg::CLS_LOAD: begin
                nxt.reg_wen      = 1'b1;
                nxt.rd           = field.inst.i.rd;
                nxt.rs1          = field.inst.i.rs1;
                nxt.src_b        = rv_decode_pkg::SRC_B_IMM;
                nxt.load         = 1'b1;
                nxt.mem_size     = rv_decode_pkg::mem_size_e'(f3[1:0]);
                nxt.mem_unsigned = f3[2];
                nxt.illegal      = (f3 == 3'b111);    // no ldu
            end
            rv_decode_pkg::CLS_STORE: begin
                nxt.rs1      = field.inst.s.rs1;
                nxt.rs2      = field.inst.s.rs2;
                nxt.src_b    = rv_decode_pkg::SRC_B_IMM;
                nxt.store    = 1'b1;
                nxt.mem_size = rv_decode_pkg::mem_size_e'(f3[1:0]);
                nxt.illegal  = f3[2];
            end
            rv_decode_pkg::CLS_LUI, rv_decode_pkg::CLS_AUIPC: begin
                nxt.reg_wen = 1'b1;
                nxt.rd      = field.inst.u.rd;
                nxt.src_b   = rv_decode_pkg::SRC_B_IMM;
                nxt.src_a   = (field.cls == rv_decode_pkg::CLS_LUI) ? rv_decode_pkg::SRC_A_ZERO
                                                                    : rv_decode_pkg::SRC_A_PC;
            end
            rv_decode_pkg::CLS_JAL, rv_decode_pkg::CLS_JALR: begin
                nxt.reg_wen = 1'b1;
                nxt.rd      = field.inst.j.rd;
                nxt.jump    = 1'b1;
                nxt.src_a   = rv_decode_pkg::SRC_A_PC;    // link = pc + 4
                nxt.src_b   = rv_decode_pkg::SRC_B_FOUR;
                if (field.cls == rv_decode_pkg::CLS_JALR) begin
                    nxt.jalr    = 1'b1;
                    nxt.rs1     = field.inst.i.rs1;
                    nxt.illegal = (f3 != 3'b000);
                end
            end
            rv_decode_pkg::CLS_BRANCH: begin
                nxt.rs1     = field.inst.b.rs1;
                nxt.rs2     = field.inst.b.rs2;
                nxt.alu_op  = rv_decode_pkg::ALU_SUB;
                nxt.branch  = 1'b1;
                nxt.illegal = (f3[2:1] == 2'b01);
                case (f3)
                    3'b000:  nxt.br_cond = rv_decode_pkg::BR_EQ;
                    3'b001:  nxt.br_cond = rv_decode_pkg::BR_NE;
                    3'b100:  nxt.br_cond = rv_decode_pkg::BR_LT;
                    3'b101:  nxt.br_cond = rv_decode_pkg::BR_GE;
                    3'b110:  nxt.br_cond = rv_decode_pkg::BR_LTU;
                    default: nxt.br_cond = rv_decode_pkg::BR_GEU;
                endcase
            end
            rv_decode_pkg::CLS_SYSTEM: begin
                nxt.ecall   = (field.inst == rv_decode_pkg::INST_ECALL);
                nxt.ebreak  = (field.inst == rv_decode_pkg::INST_EBREAK);
                nxt.mret    = (field.inst == rv_decode_pkg::INST_MRET);
                nxt.illegal = !(nxt.ecall || nxt.ebreak || nxt.mret);
            end
            default: nxt.illegal = 1'b1;
        endcase

        if (nxt.illegal) begin    // kill side effects
            nxt.reg_wen = 1'b0;
            nxt.load    = 1'b0;
            nxt.store   = 1'b0;
            nxt.branch  = 1'b0;
            nxt.jump    = 1'b0;
        end
        if (!field.valid) begin
            nxt = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            ctrl      <= '0;
        end else begin
            out_valid <= field.valid;
            ctrl      <= nxt;
        end
    end

endmodule

//--- design/rv_imm_stage.sv
`timescale 1ns/10ps

module rv_imm_stage (
    input  logic                           clk,
    input  logic                           arst_n,
    input  rv_decode_pkg::field_word_t     field,
    output logic [rv_decode_pkg::XLEN-1:0] imm
);

    localparam int XL = rv_decode_pkg::XLEN;

    rv_decode_pkg::rv_inst_t w;
    logic [XL-1:0]           imm_nxt;

    assign w = field.inst;

    always_comb begin
        case (field.fmt)
            rv_decode_pkg::IMM_I:
                imm_nxt = {{(XL-12){w.i.imm[11]}}, w.i.imm};
            rv_decode_pkg::IMM_S:
                imm_nxt = {{(XL-12){w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
            rv_decode_pkg::IMM_B:
                imm_nxt = {{(XL-12){w.b.imm_12}}, w.b.imm_11, w.b.imm_10_5,
                           w.b.imm_4_1, 1'b0};
            rv_decode_pkg::IMM_U:
                imm_nxt = {{(XL-32){w.u.imm[19]}}, w.u.imm, 12'b0};
            rv_decode_pkg::IMM_J:
                imm_nxt = {{(XL-20){w.j.imm_20}}, w.j.imm_19_12, w.j.imm_11,
                           w.j.imm_10_1, 1'b0};
            rv_decode_pkg::IMM_SHAMT:
                imm_nxt = {{(XL-6){1'b0}}, w.i.imm[5:0]};    // shamt, zero extended
            default:
                imm_nxt = '0;
        endcase
    end

    // held through bubbles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            imm <= '0;
        end else if (field.valid) begin
            imm <= imm_nxt;
        end
    end

endmodule

//--- design/rv_decode_top.sv
`timescale 1ns/10ps

module rv_decode_top (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           in_valid,
    input  rv_decode_pkg::rv_inst_t        inst,
    output logic                           out_valid,
    output rv_decode_pkg::ctrl_word_t      ctrl,
    output logic [rv_decode_pkg::XLEN-1:0] imm
);

    rv_decode_pkg::field_word_t field;    // stage 1 result, feeds both stage 2 blocks

    rv_field_stage u_field (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .inst     (inst),
        .field    (field)
    );

    rv_ctrl_stage u_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .field     (field),
        .out_valid (out_valid),
        .ctrl      (ctrl)
    );

    rv_imm_stage u_imm (
        .clk    (clk),
        .arst_n (arst_n),
        .field  (field),
        .imm    (imm)
    );

endmodule

//--- sim/rv_decode_properties.sv
`timescale 1ns/10ps

module rv_decode_properties (
    input logic                      clk,
    input logic                      arst_n,
    input logic                      in_valid,
    input logic                      out_valid,
    input rv_decode_pkg::ctrl_word_t ctrl
);

    // two register stages between in_valid and out_valid
    property valid_two_cycles;
        @(posedge clk) disable iff (!arst_n)
            out_valid == $past(in_valid, 2);
    endproperty

    property illegal_no_side_effects;
        @(posedge clk) disable iff (!arst_n)
            ctrl.illegal |-> !(ctrl.reg_wen || ctrl.store || ctrl.branch || ctrl.jump);
    endproperty

    property quiet_in_reset;
        @(posedge clk)
            !arst_n |-> !out_valid;
    endproperty

    valid_latency_a : assert property (valid_two_cycles)
        else $error("out_valid does not follow in_valid by two cycles");

    illegal_flags_a : assert property (illegal_no_side_effects)
        else $error("illegal word carries a side-effect flag");

    reset_valid_a : assert property (quiet_in_reset)
        else $error("out_valid high during reset");

endmodule

bind rv_decode_top rv_decode_properties props0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .ctrl      (ctrl)
);

//--- sim/tb_rv_decode.sv
`timescale 1ns/10ps

module tb_rv_decode;

    localparam int N_INST  = 400;
    localparam int TIMEOUT = 20;    // idle cycles allowed before giving up

    logic                           clk;
    logic                           arst_n = 1'b1;
    logic                           in_valid;
    rv_decode_pkg::rv_inst_t        inst;
    logic                           out_valid;
    rv_decode_pkg::ctrl_word_t      ctrl;
    logic [rv_decode_pkg::XLEN-1:0] imm;

    rv_decode_pkg::ctrl_word_t exp_ctrl_q[$];
    logic [63:0]               exp_imm_q[$];
    int                        n_checked = 0;

    rv_decode_top dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .inst      (inst),
        .out_valid (out_valid),
        .ctrl      (ctrl),
        .imm       (imm)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic end_with_failure();
        $display("Simulation FAILED");
        $fatal(1, "stopping after first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] want);
        assert (got === want)
            else begin
                $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, want);
                end_with_failure();
            end
    endtask

    function automatic rv_decode_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic alt);
        rv_decode_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
            3'b001:  op = rv_decode_pkg::ALU_SLL;
            3'b010:  op = rv_decode_pkg::ALU_SLT;
            3'b011:  op = rv_decode_pkg::ALU_SLTU;
            3'b100:  op = rv_decode_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
            3'b110:  op = rv_decode_pkg::ALU_OR;
            default: op = rv_decode_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // expected control word and immediate, straight from the ISA encoding
    task automatic predict(input logic [31:0] w, output rv_decode_pkg::ctrl_word_t c,
                           output logic [63:0] im);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       shift;
        logic       ok;
        f3    = w[14:12];
        f7    = w[31:25];
        shift = (f3 == 3'b001) || (f3 == 3'b101);
        ok    = 1'b1;
        c     = '0;
        im    = '0;
        case (w[6:0])
            rv_decode_pkg::OPC_OP, rv_decode_pkg::OPC_OP_32: begin
                c.reg_wen = 1'b1;
                c.rd      = w[11:7];
                c.rs1     = w[19:15];
                c.rs2     = w[24:20];
                c.alu_op  = alu_of(f3, w[30]);
                c.word_op = (w[6:0] == rv_decode_pkg::OPC_OP_32);
                if (c.word_op) begin
                    ok = (f3 == 3'b000 || f3 == 3'b101) ? (f7 == 7'b0 || f7 == 7'b0100000)
                                                        : (f3 == 3'b001 && f7 == 7'b0);
                end else begin
                    ok = (f7 == 7'b0) || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
                end
            end
            rv_decode_pkg::OPC_OP_IMM, rv_decode_pkg::OPC_OP_IMM_32: begin
                c.reg_wen = 1'b1;
                c.rd      = w[11:7];
                c.rs1     = w[19:15];
                c.src_b   = rv_decode_pkg::SRC_B_IMM;
                c.alu_op  = alu_of(f3, f3 == 3'b101 && w[30]);
                c.word_op = (w[6:0] == rv_decode_pkg::OPC_OP_IMM_32);
                im = shift ? {58'b0, w[25:20]} : {{52{w[31]}}, w[31:20]};
                if (c.word_op) begin
                    ok = (f3 == 3'b000) || (f3 == 3'b001 && f7 == 7'b0)
                         || (f3 == 3'b101 && (f7 == 7'b0 || f7 == 7'b0100000));
                end else begin
                    ok = !shift || w[31:26] == 6'b0 || (f3 == 3'b101 && w[31:26] == 6'b010000);
                end
            end
            rv_decode_pkg::OPC_LOAD: begin
                c.reg_wen      = 1'b1;
                c.rd           = w[11:7];
                c.rs1          = w[19:15];
                c.src_b        = rv_decode_pkg::SRC_B_IMM;
                c.load         = 1'b1;
                c.mem_size     = rv_decode_pkg::mem_size_e'(f3[1:0]);
                c.mem_unsigned = f3[2];
                im = {{52{w[31]}}, w[31:20]};
                ok = (f3 != 3'b111);    // ldu does not exist
            end
            rv_decode_pkg::OPC_STORE: begin
                c.rs1      = w[19:15];
                c.rs2      = w[24:20];
                c.src_b    = rv_decode_pkg::SRC_B_IMM;
                c.store    = 1'b1;
                c.mem_size = rv_decode_pkg::mem_size_e'(f3[1:0]);
                im = {{52{w[31]}}, w[31:25], w[11:7]};
                ok = !f3[2];
            end
            rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC: begin
                c.reg_wen = 1'b1;
                c.rd      = w[11:7];
                c.src_b   = rv_decode_pkg::SRC_B_IMM;
                c.src_a   = (w[6:0] == rv_decode_pkg::OPC_LUI) ? rv_decode_pkg::SRC_A_ZERO
                                                               : rv_decode_pkg::SRC_A_PC;
                im = {{32{w[31]}}, w[31:12], 12'b0};
            end
            rv_decode_pkg::OPC_JAL, rv_decode_pkg::OPC_JALR: begin
                c.reg_wen = 1'b1;
                c.rd      = w[11:7];
                c.jump    = 1'b1;
                c.src_a   = rv_decode_pkg::SRC_A_PC;
                c.src_b   = rv_decode_pkg::SRC_B_FOUR;
                if (w[6:0] == rv_decode_pkg::OPC_JALR) begin
                    c.jalr = 1'b1;
                    c.rs1  = w[19:15];
                    im = {{52{w[31]}}, w[31:20]};
                    ok = (f3 == 3'b000);
                end else begin
                    im = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
            end
            rv_decode_pkg::OPC_BRANCH: begin
                c.rs1    = w[19:15];
                c.rs2    = w[24:20];
                c.alu_op = rv_decode_pkg::ALU_SUB;
                c.branch = 1'b1;
                im = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                ok = (f3 != 3'b010) && (f3 != 3'b011);
                case (f3)
                    3'b001:  c.br_cond = rv_decode_pkg::BR_NE;
                    3'b100:  c.br_cond = rv_decode_pkg::BR_LT;
                    3'b101:  c.br_cond = rv_decode_pkg::BR_GE;
                    3'b110:  c.br_cond = rv_decode_pkg::BR_LTU;
                    3'b111:  c.br_cond = rv_decode_pkg::BR_GEU;
                    default: c.br_cond = rv_decode_pkg::BR_EQ;
                endcase
            end
            rv_decode_pkg::OPC_SYSTEM: begin
                c.ecall  = (w == rv_decode_pkg::INST_ECALL);
                c.ebreak = (w == rv_decode_pkg::INST_EBREAK);
                c.mret   = (w == rv_decode_pkg::INST_MRET);
                ok = c.ecall || c.ebreak || c.mret;
            end
            default: ok = 1'b0;
        endcase
        c.illegal = !ok;
        if (c.illegal) begin
            c.reg_wen = 1'b0;
            c.load    = 1'b0;
            c.store   = 1'b0;
            c.branch  = 1'b0;
            c.jump    = 1'b0;
        end
    endtask

    // funct7 for register ops, mostly legal with a bad value now and then
    function automatic logic [6:0] pick_f7();
        logic [6:0] f7;
        case ($urandom_range(0, 3))
            0:       f7 = 7'b0000001;
            1:       f7 = 7'b0100000;
            default: f7 = 7'b0000000;
        endcase
        return f7;
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        w = $urandom;
        case ($urandom_range(0, 12))
            0: begin
                w[6:0]   = rv_decode_pkg::OPC_OP;
                w[31:25] = pick_f7();    // alt form legal only for sub / sra
            end
            1: begin
                w[6:0]   = rv_decode_pkg::OPC_OP_32;
                w[31:25] = pick_f7();
            end
            2: begin
                w[6:0] = rv_decode_pkg::OPC_OP_IMM;
                if (w[14:12] == 3'b001 || w[14:12] == 3'b101) begin
                    case ($urandom_range(0, 2))
                        0:       w[31:26] = 6'b000001;
                        1:       w[31:26] = 6'b010000;
                        default: w[31:26] = 6'b000000;
                    endcase
                end
            end
            3: begin
                w[6:0] = rv_decode_pkg::OPC_OP_IMM_32;
                if (w[14:12] == 3'b001 || w[14:12] == 3'b101) begin
                    w[31:25] = pick_f7();
                end
            end
            4:  w[6:0] = rv_decode_pkg::OPC_LOAD;
            5:  w[6:0] = rv_decode_pkg::OPC_STORE;
            6:  w[6:0] = rv_decode_pkg::OPC_LUI;
            7:  w[6:0] = rv_decode_pkg::OPC_AUIPC;
            8:  w[6:0] = rv_decode_pkg::OPC_JAL;
            9: begin
                w[6:0] = rv_decode_pkg::OPC_JALR;
                if ($urandom_range(0, 3) != 0) begin
                    w[14:12] = 3'b000;
                end
            end
            10: w[6:0] = rv_decode_pkg::OPC_BRANCH;
            11: begin
                case ($urandom_range(0, 3))
                    0:       w = rv_decode_pkg::INST_ECALL;
                    1:       w = rv_decode_pkg::INST_EBREAK;
                    2:       w = rv_decode_pkg::INST_MRET;
                    default: w[6:0] = rv_decode_pkg::OPC_SYSTEM;
                endcase
            end
            default: w[1:0] = 2'($urandom_range(0, 2));    // outside the 32-bit opcode space
        endcase
        return w;
    endfunction

    task automatic drive_all();
        logic [31:0]               w;
        rv_decode_pkg::ctrl_word_t c;
        logic [63:0]               im;
        int                        gap;
        for (int k = 0; k < N_INST; k++) begin
            w = random_inst();
            predict(w, c, im);
            exp_ctrl_q.push_back(c);
            exp_imm_q.push_back(im);
            @(posedge clk);
            in_valid <= 1'b1;
            inst     <= w;
            gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                in_valid <= 1'b0;
                inst     <= $urandom;    // junk on the bus during a bubble
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic compare_out();
        rv_decode_pkg::ctrl_word_t e;
        logic [63:0]               ei;
        e  = exp_ctrl_q.pop_front();
        ei = exp_imm_q.pop_front();
        check_val("illegal", 64'(ctrl.illegal), 64'(e.illegal));
        check_val("reg_wen", 64'(ctrl.reg_wen), 64'(e.reg_wen));
        check_val("load", 64'(ctrl.load), 64'(e.load));
        check_val("store", 64'(ctrl.store), 64'(e.store));
        check_val("branch", 64'(ctrl.branch), 64'(e.branch));
        check_val("jump", 64'(ctrl.jump), 64'(e.jump));
        check_val("ecall", 64'(ctrl.ecall), 64'(e.ecall));
        check_val("ebreak", 64'(ctrl.ebreak), 64'(e.ebreak));
        check_val("mret", 64'(ctrl.mret), 64'(e.mret));
        if (!e.illegal) begin    // the rest only means something for a legal word
            check_val("rd", 64'(ctrl.rd), 64'(e.rd));
            check_val("rs1", 64'(ctrl.rs1), 64'(e.rs1));
            check_val("rs2", 64'(ctrl.rs2), 64'(e.rs2));
            check_val("alu_op", 64'(ctrl.alu_op), 64'(e.alu_op));
            check_val("src_a", 64'(ctrl.src_a), 64'(e.src_a));
            check_val("src_b", 64'(ctrl.src_b), 64'(e.src_b));
            check_val("word_op", 64'(ctrl.word_op), 64'(e.word_op));
            check_val("mem_size", 64'(ctrl.mem_size), 64'(e.mem_size));
            check_val("mem_unsigned", 64'(ctrl.mem_unsigned), 64'(e.mem_unsigned));
            check_val("br_cond", 64'(ctrl.br_cond), 64'(e.br_cond));
            check_val("jalr", 64'(ctrl.jalr), 64'(e.jalr));
            check_val("imm", imm, ei);
        end
    endtask

    task automatic watch_outputs();
        int idle;
        idle = 0;
        while (n_checked < N_INST) begin
            @(negedge clk);
            if (out_valid && exp_ctrl_q.size() == 0) begin
                $display("out_valid went high with no instruction outstanding");
                end_with_failure();
            end else if (out_valid) begin
                compare_out();
                n_checked++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    $display("timeout, no out_valid for %0d cycles", TIMEOUT);
                    end_with_failure();
                end
            end
        end
    endtask

    initial begin
        void'($urandom(67));
        in_valid <= 1'b0;
        inst     <= '0;
        arst_n   <= 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        fork
            drive_all();
            watch_outputs();
        join
        if (exp_ctrl_q.size() == 0 && n_checked == N_INST) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("%0d expected results were never checked", exp_ctrl_q.size());
            end_with_failure();
        end
    end

endmodule

//--- all.f
design/rv_decode_pkg.sv
design/rv_field_stage.sv
design/rv_ctrl_stage.sv
design/rv_imm_stage.sv
design/rv_decode_top.sv
sim/rv_decode_properties.sv
sim/tb_rv_decode.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module tb_rv_decode -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run.sh: pass" ||
{ echo "run.sh: fail"; exit 1; }
